// File: design/fpAddCore.sv
`timescale 1ns/10ps

module fpAddCore #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
) (
    input  logic  clk,
    input  logic  rstN,
    fpPairIf.dst  pairIn,
    fpSumIf.src   sumOut
);

    localparam int sigWidth = fracWidth + 1;

    logic                resSign;
    logic [expWidth-1:0] resExp;
    logic [sigWidth:0]   resMag;

    // sign and exponent follow the larger operand
    always_comb begin
        resSign = pairIn.signA;
        resExp  = pairIn.expA;
        if (pairIn.op == fpPkg::opAdd) begin
            resMag = {1'b0, pairIn.sigA} + {1'b0, pairIn.sigB};
        end else begin
            resMag = {1'b0, pairIn.sigA} - {1'b0, pairIn.sigB};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sumOut.valid <= 1'b0;
        end else begin
            sumOut.valid <= pairIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        sumOut.sign <= resSign;
        sumOut.exp  <= resExp;
        sumOut.mag  <= resMag;
    end

    // alignment puts the larger magnitude on A, so no borrow reaches the top bit
    aNoBorrow : assert property (@(posedge clk) disable iff (!rstN)
        (pairIn.valid && (pairIn.op == fpPkg::opSub)) |=> !sumOut.mag[sigWidth])
        else $error("fpAddCore: subtraction borrowed");

endmodule

// File: design/fpAdder.sv
`timescale 1ns/10ps

module fpAdder #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    input  fpPkg::fpOp                  op,
    input  logic [expWidth+fracWidth:0] a,
    input  logic [expWidth+fracWidth:0] b,
    output logic                        outValid,
    output logic [expWidth+fracWidth:0] result
);

    // *******************************************************************
    // stage links
    // *******************************************************************

    fpPairIf #(.expWidth(expWidth), .fracWidth(fracWidth)) unpacked ();
    fpPairIf #(.expWidth(expWidth), .fracWidth(fracWidth)) aligned ();
    fpSumIf  #(.expWidth(expWidth), .fracWidth(fracWidth)) summed ();

    // *******************************************************************
    // four-stage pipeline, one cycle each
    // *******************************************************************

    fpUnpack #(.expWidth(expWidth), .fracWidth(fracWidth)) uUnpack (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .op      (op),
        .a       (a),
        .b       (b),
        .pairOut (unpacked.src)
    );

    fpAlign #(.expWidth(expWidth), .fracWidth(fracWidth)) uAlign (
        .clk     (clk),
        .rstN    (rstN),
        .pairIn  (unpacked.dst),
        .pairOut (aligned.src)
    );

    fpAddCore #(.expWidth(expWidth), .fracWidth(fracWidth)) uAddCore (
        .clk    (clk),
        .rstN   (rstN),
        .pairIn (aligned.dst),
        .sumOut (summed.src)
    );

    fpNormalize #(.expWidth(expWidth), .fracWidth(fracWidth)) uNormalize (
        .clk      (clk),
        .rstN     (rstN),
        .sumIn    (summed.dst),
        .outValid (outValid),
        .result   (result)
    );

endmodule

// File: design/fpAlign.sv
`timescale 1ns/10ps

module fpAlign #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
) (
    input  logic  clk,
    input  logic  rstN,
    fpPairIf.dst  pairIn,
    fpPairIf.src  pairOut
);

    localparam int sigWidth = fracWidth + 1;

    logic                effSignB;
    logic                swap;
    logic                bigSign;
    logic                smallSign;
    logic [expWidth-1:0] bigExp;
    logic [expWidth-1:0] smallExp;
    logic [expWidth-1:0] expDiff;
    logic [sigWidth-1:0] bigSig;
    logic [sigWidth-1:0] smallSig;
    logic [sigWidth-1:0] alignedSig;

    // subtraction is addition of the negated operand
    assign effSignB = pairIn.signB ^ (pairIn.op == fpPkg::opSub);

    // *******************************************************************
    // magnitude order, exponent first then significand
    // *******************************************************************

    // ties stay on the A side
    assign swap = (pairIn.expB > pairIn.expA) ||
                  ((pairIn.expB == pairIn.expA) && (pairIn.sigB > pairIn.sigA));

    assign bigSign   = swap ? effSignB    : pairIn.signA;
    assign bigExp    = swap ? pairIn.expB : pairIn.expA;
    assign bigSig    = swap ? pairIn.sigB : pairIn.sigA;
    assign smallSign = swap ? pairIn.signA : effSignB;
    assign smallExp  = swap ? pairIn.expA  : pairIn.expB;
    assign smallSig  = swap ? pairIn.sigA  : pairIn.sigB;

    // *******************************************************************
    // alignment shift
    // *******************************************************************

    assign expDiff = bigExp - smallExp;

    // shifted-out bits are dropped, nothing survives a full-width shift
    assign alignedSig = (expDiff >= sigWidth) ? '0 : (smallSig >> expDiff);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pairOut.valid <= 1'b0;
        end else begin
            pairOut.valid <= pairIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        pairOut.op    <= (bigSign != smallSign) ? fpPkg::opSub : fpPkg::opAdd;
        pairOut.signA <= bigSign;
        pairOut.expA  <= bigExp;
        pairOut.sigA  <= bigSig;
        pairOut.signB <= smallSign;
        pairOut.expB  <= smallExp;
        pairOut.sigB  <= alignedSig;
    end

    // the adder relies on A carrying the larger exponent
    property pExpOrder;
        @(posedge clk) disable iff (!rstN)
            pairOut.valid |-> (pairOut.expA >= pairOut.expB);
    endproperty

    aExpOrder : assert property (pExpOrder)
        else $error("fpAlign: expA below expB on output");

endmodule

// File: design/fpNormalize.sv
`timescale 1ns/10ps

module fpNormalize #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
) (
    input  logic                        clk,
    input  logic                        rstN,
    fpSumIf.dst                         sumIn,
    output logic                        outValid,
    output logic [expWidth+fracWidth:0] result
);

    localparam int sigWidth = fracWidth + 1;
    localparam int cntWidth = $clog2(sigWidth + 1);

    logic                carry;
    logic                isZero;
    logic                found;
    logic [cntWidth-1:0] lzCount;
    logic [sigWidth-1:0] normSig;
    logic [expWidth-1:0] normExp;

    assign carry  = sumIn.mag[sigWidth];
    assign isZero = (sumIn.mag == '0);

    // *******************************************************************
    // leading-one search below the carry bit
    // *******************************************************************

    always_comb begin
        lzCount = '0;
        found   = 1'b0;
        for (int i = sigWidth - 1; i >= 0; i--) begin
            if (sumIn.mag[i]) begin
                found = 1'b1;
            end else if (!found) begin
                lzCount = lzCount + 1'b1;
            end
        end
    end

    // *******************************************************************
    // normalizing shift and exponent correction
    // *******************************************************************

    always_comb begin
        if (carry) begin
            // one step right, the low bit is truncated
            normSig = sumIn.mag[sigWidth:1];
            normExp = sumIn.exp + 1'b1;
        end else begin
            normSig = sumIn.mag[sigWidth-1:0] << lzCount;
            normExp = sumIn.exp - expWidth'(lzCount);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sumIn.valid;
        end
    end

    // exact cancellation always packs as +0
    always_ff @(posedge clk) begin
        if (isZero) begin
            result <= '0;
        end else begin
            result <= {sumIn.sign, normExp, normSig[fracWidth-1:0]};
        end
    end

    aHiddenBit : assert property (@(posedge clk) disable iff (!rstN)
        (sumIn.valid && !isZero) |-> normSig[fracWidth])
        else $error("fpNormalize: hidden bit clear after shift");

endmodule

// File: design/fpPkg.sv
package fpPkg;

    // *******************************************************************
    // operation codes
    // *******************************************************************

    // applied to operand B; after alignment it holds the effective operation
    typedef enum logic {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp;

    // *******************************************************************
    // default number format
    // *******************************************************************

    // IEEE-754 single precision
    localparam int defExpWidth  = 8;
    // stored fraction, hidden bit not included
    localparam int defFracWidth = 23;

endpackage

// File: design/fpStageIf.sv
`timescale 1ns/10ps

// *******************************************************************
// operand pair between unpack, align and add stages
// *******************************************************************
interface fpPairIf #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
);

    localparam int sigWidth = fracWidth + 1;

    logic                valid;
    fpPkg::fpOp          op;
    logic                signA;
    logic [expWidth-1:0] expA;
    logic [sigWidth-1:0] sigA;
    logic                signB;
    logic [expWidth-1:0] expB;
    logic [sigWidth-1:0] sigB;

    modport src (
        output valid, op,
        output signA, expA, sigA,
        output signB, expB, sigB
    );

    modport dst (
        input valid, op,
        input signA, expA, sigA,
        input signB, expB, sigB
    );

endinterface

// *******************************************************************
// raw magnitude between add and normalize stages
// *******************************************************************
interface fpSumIf #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
);

    localparam int sigWidth = fracWidth + 1;

    logic                valid;
    logic                sign;
    logic [expWidth-1:0] exp;
    // top bit is the carry out of the significand add
    logic [sigWidth:0]   mag;

    modport src (output valid, sign, exp, mag);
    modport dst (input valid, sign, exp, mag);

endinterface

// File: design/fpUnpack.sv
`timescale 1ns/10ps

module fpUnpack #(
    parameter int expWidth  = fpPkg::defExpWidth,
    parameter int fracWidth = fpPkg::defFracWidth
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    input  fpPkg::fpOp                  op,
    input  logic [expWidth+fracWidth:0] a,
    input  logic [expWidth+fracWidth:0] b,
    fpPairIf.src                        pairOut
);

    localparam int sigWidth  = fracWidth + 1;
    localparam int wordWidth = expWidth + fracWidth + 1;

    logic                signA;
    logic                signB;
    logic [expWidth-1:0] expA;
    logic [expWidth-1:0] expB;
    logic [sigWidth-1:0] sigA;
    logic [sigWidth-1:0] sigB;

    // field split
    assign signA = a[wordWidth-1];
    assign signB = b[wordWidth-1];
    assign expA  = a[wordWidth-2 -: expWidth];
    assign expB  = b[wordWidth-2 -: expWidth];

    // hidden bit restored, a zero exponent reads as zero
    assign sigA = (expA == '0) ? '0 : {1'b1, a[fracWidth-1:0]};
    assign sigB = (expB == '0) ? '0 : {1'b1, b[fracWidth-1:0]};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pairOut.valid <= 1'b0;
        end else begin
            pairOut.valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        pairOut.op    <= op;
        pairOut.signA <= signA;
        pairOut.expA  <= expA;
        pairOut.sigA  <= sigA;
        pairOut.signB <= signB;
        pairOut.expB  <= expB;
        pairOut.sigB  <= sigB;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile and run the fpAdder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fpAdderTb -f verilog.f -o fpAdderSim > build.log 2>&1 \
    && ./obj_dir/fpAdderSim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

# the log decides the status
grep -q ">>> FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

// File: verification/fpModel.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// single precision fields seen by the reference model
localparam int mExpW  = fpPkg::defExpWidth;
localparam int mFracW = fpPkg::defFracWidth;
localparam int mSigW  = mFracW + 1;
localparam int mWordW = mExpW + mFracW + 1;

// 32-bit LCG step, wraps modulo 2**32
function automatic logic [31:0] lcgStep(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// add or subtract with truncation, zero exponent reads as zero
function automatic logic [mWordW-1:0] modelAddSub(
    input fpPkg::fpOp        op,
    input logic [mWordW-1:0] a,
    input logic [mWordW-1:0] b
);
    logic sA;
    logic sB;
    logic sBig;
    logic sSmall;
    int   eA;
    int   eB;
    int   eBig;
    int   eSmall;
    int   mA;
    int   mB;
    int   mBig;
    int   mSmall;
    int   mag;

    sA = a[mWordW-1];
    sB = b[mWordW-1] ^ (op == fpPkg::opSub);
    eA = int'(a[mWordW-2 -: mExpW]);
    eB = int'(b[mWordW-2 -: mExpW]);
    mA = (eA == 0) ? 0 : ((1 << mFracW) | int'(a[mFracW-1:0]));
    mB = (eB == 0) ? 0 : ((1 << mFracW) | int'(b[mFracW-1:0]));

    // larger magnitude goes first, a tie keeps A in front
    if ((eB > eA) || ((eB == eA) && (mB > mA))) begin
        sBig   = sB;
        eBig   = eB;
        mBig   = mB;
        sSmall = sA;
        eSmall = eA;
        mSmall = mA;
    end else begin
        sBig   = sA;
        eBig   = eA;
        mBig   = mA;
        sSmall = sB;
        eSmall = eB;
        mSmall = mB;
    end

    mSmall = ((eBig - eSmall) >= mSigW) ? 0 : (mSmall >> (eBig - eSmall));
    mag    = (sBig == sSmall) ? (mBig + mSmall) : (mBig - mSmall);

    if (mag == 0) begin
        return '0;
    end
    if (mag >= (1 << mSigW)) begin
        mag  = mag / 2;
        eBig = eBig + 1;
    end
    while (mag < (1 << mFracW)) begin
        mag  = mag * 2;
        eBig = eBig - 1;
    end
    return {sBig, mExpW'(eBig), mFracW'(mag)};
endfunction

`endif

// File: verification/fpAdderTb.sv
`timescale 1ns/10ps

module fpAdderTb;

    `include "fpModel.svh"

    localparam int numDirected = 16;
    localparam int numRandom   = 200;
    localparam int numCases    = numDirected + numRandom;
    localparam int latency     = 4;
    localparam int resetCycles = 8;
    localparam int clkPeriod   = 4;

    typedef struct packed {
        fpPkg::fpOp        op;
        logic [mWordW-1:0] a;
        logic [mWordW-1:0] b;
        logic [mWordW-1:0] expected;
    } dirCase;

    logic              clk;
    logic              rstN;
    logic              inValid;
    fpPkg::fpOp        op;
    logic [mWordW-1:0] a;
    logic [mWordW-1:0] b;
    logic              outValid;
    logic [mWordW-1:0] result;

    dirCase            dirTable [numDirected];
    logic [mWordW-1:0] expQ [$];
    int                issueQ [$];
    logic [mWordW-1:0] expVal;
    int                issued;
    logic [31:0]       lcgState;
    int                cycleCount = 0;
    int                checkedCount = 0;
    int                valueErrors = 0;
    int                otherErrors = 0;

    fpAdder #(
        .expWidth  (fpPkg::defExpWidth),
        .fracWidth (fpPkg::defFracWidth)
    ) dut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .op       (op),
        .a        (a),
        .b        (b),
        .outValid (outValid),
        .result   (result)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // *******************************************************************
    // stimulus
    // *******************************************************************

    task automatic loadTable();
        dirTable[0]  = '{fpPkg::opAdd, 32'h3FC00000, 32'h3FC00000, 32'h40400000};
        dirTable[1]  = '{fpPkg::opAdd, 32'hBFC00000, 32'hBFC00000, 32'hC0400000};
        dirTable[2]  = '{fpPkg::opAdd, 32'h3F800001, 32'h3F800000, 32'h40000000};
        dirTable[3]  = '{fpPkg::opAdd, 32'h3F800000, 32'h3F000001, 32'h3FC00000};
        dirTable[4]  = '{fpPkg::opAdd, 32'h3F800000, 32'h34000000, 32'h3F800001};
        dirTable[5]  = '{fpPkg::opAdd, 32'h3F800000, 32'h33800000, 32'h3F800000};
        dirTable[6]  = '{fpPkg::opAdd, 32'h3F800000, 32'h30800000, 32'h3F800000};
        dirTable[7]  = '{fpPkg::opSub, 32'h3F800001, 32'h3F800000, 32'h34000000};
        dirTable[8]  = '{fpPkg::opSub, 32'h40490FDB, 32'h40490FDB, 32'h00000000};
        dirTable[9]  = '{fpPkg::opSub, 32'h3F800000, 32'h40000000, 32'hBF800000};
        dirTable[10] = '{fpPkg::opAdd, 32'h40A00000, 32'hC0400000, 32'h40000000};
        dirTable[11] = '{fpPkg::opAdd, 32'h00000000, 32'h40490FDB, 32'h40490FDB};
        dirTable[12] = '{fpPkg::opSub, 32'h3F800000, 32'h00000000, 32'h3F800000};
        dirTable[13] = '{fpPkg::opSub, 32'h00000000, 32'h3F800000, 32'hBF800000};
        dirTable[14] = '{fpPkg::opAdd, 32'h3F800000, 32'hBF800000, 32'h00000000};
        dirTable[15] = '{fpPkg::opSub, 32'h3FC00000, 32'h3F800000, 32'h3F000000};
    endtask

    // operands stay between exponents 40 and 200, B within 30 of A
    task automatic makePair(output fpPkg::fpOp pairOp, output logic [mWordW-1:0] pa,
                            output logic [mWordW-1:0] pb);
        int expA;
        int expB;

        lcgState = lcgStep(lcgState);
        expA     = 40 + int'(lcgState[31:16] % 16'd161);
        lcgState = lcgStep(lcgState);
        expB     = expA + int'(lcgState[31:24] % 8'd61) - 30;
        expB     = (expB < 40) ? 40 : ((expB > 200) ? 200 : expB);
        pairOp   = fpPkg::fpOp'(lcgState[23]);
        lcgState = lcgStep(lcgState);
        pa       = {lcgState[31], mExpW'(expA), lcgState[30:8]};
        lcgState = lcgStep(lcgState);
        pb       = {lcgState[31], mExpW'(expB), lcgState[30:8]};
    endtask

    // called on a falling edge, returns on the next one
    task automatic applyItem(input fpPkg::fpOp itemOp, input logic [mWordW-1:0] itemA,
                             input logic [mWordW-1:0] itemB, input logic [mWordW-1:0] expected);
        inValid = 1'b1;
        op      = itemOp;
        a       = itemA;
        b       = itemB;
        expQ.push_back(expected);
        issueQ.push_back(cycleCount);
        @(negedge clk);
    endtask

    initial begin
        fpPkg::fpOp        rop;
        logic [mWordW-1:0] ra;
        logic [mWordW-1:0] rb;
        int                drain;

        rstN     = 1'b0;
        // a strobe during reset must not enter the pipeline
        inValid  = 1'b1;
        op       = fpPkg::opAdd;
        a        = '0;
        b        = '0;
        lcgState = 32'd75;
        loadTable();
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        // directed entries back to back
        for (int i = 0; i < numDirected; i++) begin
            assert (modelAddSub(dirTable[i].op, dirTable[i].a, dirTable[i].b)
                    == dirTable[i].expected)
            else begin
                otherErrors++;
                $display("reference model disagrees with table entry %0d", i);
            end
            applyItem(dirTable[i].op, dirTable[i].a, dirTable[i].b, dirTable[i].expected);
        end
        inValid = 1'b0;
        repeat (2) @(negedge clk);

        for (int i = 0; i < numRandom; i++) begin
            makePair(rop, ra, rb);
            applyItem(rop, ra, rb, modelAddSub(rop, ra, rb));
        end
        inValid = 1'b0;

        drain = 0;
        while ((expQ.size() != 0) && (drain < 2 * latency)) begin
            @(negedge clk);
            drain++;
        end
        assert (expQ.size() == 0) else begin
            otherErrors++;
            $display("%0d results never came out of the pipeline", expQ.size());
        end

        $display("checked %0d results: %0d value errors, %0d other errors",
                 checkedCount, valueErrors, otherErrors);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // *******************************************************************
    // checker, outputs sampled on the falling edge
    // *******************************************************************

    always @(negedge clk) begin
        if (!rstN) begin
            assert (outValid == 1'b0) else begin
                valueErrors++;
                $display("ERR t=%0t outValid got %b expected 0", $time, outValid);
            end
        end else if (outValid) begin
            assert (expQ.size() != 0) else begin
                otherErrors++;
                $display("outValid went high at %0t with no result outstanding", $time);
            end
            if (expQ.size() != 0) begin
                expVal = expQ.pop_front();
                issued = issueQ.pop_front();
                checkedCount++;
                assert (result == expVal) else begin
                    valueErrors++;
                    $display("ERR t=%0t result got %h expected %h", $time, result, expVal);
                end
                assert ((cycleCount - issued) == latency) else begin
                    otherErrors++;
                    $display("result at %0t came %0d cycles after its input instead of %0d",
                             $time, cycleCount - issued, latency);
                end
            end
        end
    end

    // watchdog
    initial begin
        #((numCases + latency + resetCycles) * clkPeriod * 2);
        $display("timeout: the run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
design/fpPkg.sv
design/fpStageIf.sv
design/fpUnpack.sv
design/fpAlign.sv
design/fpAddCore.sv
design/fpNormalize.sv
design/fpAdder.sv
verification/fpAdderTb.sv
